//--- design/cmd_pkg.sv
package cmd_pkg;

    // ==================================================
    // frame bytes
    // ==================================================
    localparam logic [7:0] SYNC_BYTE = 8'h55;
    // reply for an opcode the decoder does not know
    localparam logic [7:0] NAK_BYTE = 8'hEE;

    // pwm outputs
    localparam int PWM_CHANNELS = 8;

    // clocks per uart bit, kept small for simulation
    localparam int UART_DIV = 8;
    localparam int UART_CNT_W = $clog2(UART_DIV);

    // ==================================================
    // command types
    // ==================================================
    typedef enum logic [7:0] {
        OP_PWM_DUTY  = 8'h01,
        OP_UART_SEND = 8'h02,
        OP_LED       = 8'h03,
        OP_ECHO      = 8'h04
    } opcode_e;

    // one decoded frame, sync byte stripped
    typedef struct packed {
        opcode_e    opcode;
        logic [7:0] addr;
        logic [7:0] data;
    } cmd_t;

    // byte going up to the usb core
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } upload_t;

endpackage

//--- design/frame_parser.sv
`timescale 1ns/1ns

module frame_parser (
    input  logic          clk,
    input  logic          arst_n_i,
    input  logic [7:0]    byte_i,
    input  logic          byte_valid_i,
    output cmd_pkg::cmd_t cmd_o,
    output logic          cmd_valid_o,
    output logic          nak_valid_o
);
    import cmd_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        OPCODE,
        ADDR,
        DATA
    } state_e;

    state_e     state_q;
    logic [7:0] opcode_q;
    logic [7:0] addr_q;
    logic       op_known;

    // opcode check against the supported set
    always_comb begin
        case (opcode_q)
            OP_PWM_DUTY, OP_UART_SEND, OP_LED, OP_ECHO: op_known = 1'b1;
            default: op_known = 1'b0;
        endcase
    end

    // frame fsm, advances once per received byte
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= IDLE;
            cmd_valid_o <= 1'b0;
            nak_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= 1'b0;
            nak_valid_o <= 1'b0;
            if (byte_valid_i) begin
                case (state_q)
                    // anything but sync is line noise here
                    IDLE: begin
                        if (byte_i == SYNC_BYTE) begin
                            state_q <= OPCODE;
                        end
                    end
                    OPCODE: state_q <= ADDR;
                    ADDR: state_q <= DATA;
                    DATA: begin
                        state_q     <= IDLE;
                        cmd_valid_o <= op_known;
                        nak_valid_o <= !op_known;
                    end
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

    // field capture
    always_ff @(posedge clk) begin
        if (byte_valid_i) begin
            case (state_q)
                OPCODE: opcode_q <= byte_i;
                ADDR: addr_q <= byte_i;
                DATA: begin
                    cmd_o.opcode <= opcode_e'(opcode_q);
                    cmd_o.addr   <= addr_q;
                    cmd_o.data   <= byte_i;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- design/pwm_bank.sv
`timescale 1ns/1ns

module pwm_bank (
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  cmd_pkg::cmd_t                    cmd_i,
    input  logic                             cmd_valid_i,
    output logic [cmd_pkg::PWM_CHANNELS-1:0] pwm_o
);
    import cmd_pkg::*;

    // shared period counter
    logic [7:0] cnt_q;
    // duty written by the host, applied on wrap
    logic [7:0] duty_pend_q [PWM_CHANNELS];
    logic [7:0] duty_act_q  [PWM_CHANNELS];
    logic       duty_wr;

    assign duty_wr = cmd_valid_i && (cmd_i.opcode == OP_PWM_DUTY);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
            for (int i = 0; i < PWM_CHANNELS; i++) begin
                duty_pend_q[i] <= '0;
                duty_act_q[i]  <= '0;
            end
        end else begin
            cnt_q <= cnt_q + 8'd1;
            for (int i = 0; i < PWM_CHANNELS; i++) begin
                // out of range addresses match no channel
                if (duty_wr && (cmd_i.addr == 8'(i))) begin
                    duty_pend_q[i] <= cmd_i.data;
                end
                // new period starts with the pending duty
                if (cnt_q == 8'hFF) begin
                    duty_act_q[i] <= duty_pend_q[i];
                end
            end
        end
    end

    // high while counter is below duty, so duty 0 stays low
    always_comb begin
        for (int i = 0; i < PWM_CHANNELS; i++) begin
            pwm_o[i] = (cnt_q < duty_act_q[i]);
        end
    end

endmodule

//--- design/uart_port.sv
`timescale 1ns/1ns

module uart_port (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic [7:0] tx_data_i,
    input  logic       tx_start_i,
    output logic       tx_o,
    input  logic       rx_i,
    output logic [7:0] rx_data_o,
    output logic       rx_valid_o
);
    import cmd_pkg::*;

    // ==================================================
    // transmitter, 8N1
    // ==================================================
    logic                  tx_busy;
    logic [UART_CNT_W-1:0] tx_div_q;
    logic [3:0]            tx_bit_q;
    logic [9:0]            tx_shift_q;
    logic                  tx_bit_end;

    assign tx_bit_end = (tx_div_q == UART_CNT_W'(UART_DIV - 1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tx_busy  <= 1'b0;
            tx_div_q <= '0;
            tx_bit_q <= '0;
        end else if (!tx_busy) begin
            // start while busy is simply lost
            if (tx_start_i) begin
                tx_busy  <= 1'b1;
                tx_div_q <= '0;
                tx_bit_q <= '0;
            end
        end else if (tx_bit_end) begin
            tx_div_q <= '0;
            if (tx_bit_q == 4'd9) begin
                tx_busy <= 1'b0;
            end else begin
                tx_bit_q <= tx_bit_q + 4'd1;
            end
        end else begin
            tx_div_q <= tx_div_q + 1'b1;
        end
    end

    // stop, data lsb first, start
    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start_i) begin
            tx_shift_q <= {1'b1, tx_data_i, 1'b0};
        end else if (tx_busy && tx_bit_end) begin
            tx_shift_q <= {1'b1, tx_shift_q[9:1]};
        end
    end

    // line idles high
    assign tx_o = tx_busy ? tx_shift_q[0] : 1'b1;

    // ==================================================
    // receiver
    // ==================================================
    logic                  rx_meta_q;
    logic                  rx_sync_q;
    logic                  rx_prev_q;
    logic                  rx_busy_q;
    logic [UART_CNT_W-1:0] rx_div_q;
    logic [3:0]            rx_bit_q;
    logic [7:0]            rx_shift_q;
    logic                  rx_mid;

    // sample point about half a bit in
    assign rx_mid = (rx_div_q == UART_CNT_W'(UART_DIV / 2 - 1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_meta_q  <= 1'b1;
            rx_sync_q  <= 1'b1;
            rx_prev_q  <= 1'b1;
            rx_busy_q  <= 1'b0;
            rx_div_q   <= '0;
            rx_bit_q   <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_meta_q  <= rx_i;
            rx_sync_q  <= rx_meta_q;
            rx_prev_q  <= rx_sync_q;
            rx_valid_o <= 1'b0;
            if (!rx_busy_q) begin
                // falling edge opens the start bit
                if (rx_prev_q && !rx_sync_q) begin
                    rx_busy_q <= 1'b1;
                    rx_div_q  <= '0;
                    rx_bit_q  <= '0;
                end
            end else begin
                if (rx_div_q == UART_CNT_W'(UART_DIV - 1)) begin
                    rx_div_q <= '0;
                    rx_bit_q <= rx_bit_q + 4'd1;
                end else begin
                    rx_div_q <= rx_div_q + 1'b1;
                end
                if (rx_mid) begin
                    // start bit gone high again, a glitch
                    if (rx_bit_q == 4'd0 && rx_sync_q) begin
                        rx_busy_q <= 1'b0;
                    end
                    // stop bit, framing error drops the byte
                    if (rx_bit_q == 4'd9) begin
                        rx_busy_q  <= 1'b0;
                        rx_valid_o <= rx_sync_q;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_busy_q && rx_mid) begin
            if (rx_bit_q >= 4'd1 && rx_bit_q <= 4'd8) begin
                rx_shift_q <= {rx_sync_q, rx_shift_q[7:1]};
            end
            if (rx_bit_q == 4'd9) begin
                rx_data_o <= rx_shift_q;
            end
        end
    end

endmodule

//--- design/upload_mux.sv
`timescale 1ns/1ns

module upload_mux (
    input  logic             clk,
    input  logic             arst_n_i,
    input  cmd_pkg::cmd_t    cmd_i,
    input  logic             cmd_valid_i,
    input  logic             nak_valid_i,
    input  logic [7:0]       rx_data_i,
    input  logic             rx_valid_i,
    output cmd_pkg::upload_t upload_o
);
    import cmd_pkg::*;

    logic       rx_pend_q;
    logic [7:0] rx_data_q;
    logic       reply_req;
    logic [7:0] reply_byte;
    // uart pending view including this cycle's arrival
    logic       rx_pend_d;
    logic [7:0] rx_data_d;
    logic       up_valid_q;
    logic [7:0] up_data_q;

    assign reply_req  = (cmd_valid_i && (cmd_i.opcode == OP_ECHO)) || nak_valid_i;
    assign reply_byte = nak_valid_i ? NAK_BYTE : cmd_i.data;

    // a new byte overwrites an unsent one of the same source
    assign rx_pend_d = rx_valid_i || rx_pend_q;
    assign rx_data_d = rx_valid_i ? rx_data_i : rx_data_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_pend_q  <= 1'b0;
            up_valid_q <= 1'b0;
        end else begin
            up_valid_q <= reply_req || rx_pend_d;
            // replies win and leave at once, uart bytes wait
            rx_pend_q  <= reply_req && rx_pend_d;
        end
    end

    always_ff @(posedge clk) begin
        rx_data_q <= rx_data_d;
        up_data_q <= reply_req ? reply_byte : rx_data_d;
    end

    assign upload_o = '{data: up_data_q, valid: up_valid_q};

endmodule

//--- design/cmd_ctrl.sv
`timescale 1ns/1ns

module cmd_ctrl (
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  logic [7:0]                       usb_data_i,
    input  logic                             usb_data_valid_i,
    output logic [7:0]                       usb_upload_data_o,
    output logic                             usb_upload_valid_o,
    output logic [cmd_pkg::PWM_CHANNELS-1:0] pwm_pins_o,
    input  logic                             ext_uart_rx_i,
    output logic                             ext_uart_tx_o,
    output logic                             led_o
);
    import cmd_pkg::*;

    cmd_t       cmd;
    logic       cmd_valid;
    logic       nak_valid;
    logic       tx_start;
    logic [7:0] rx_data;
    logic       rx_valid;
    upload_t    upload;

    // ==================================================
    // frame decode
    // ==================================================
    frame_parser u_parser (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .byte_i       (usb_data_i),
        .byte_valid_i (usb_data_valid_i),
        .cmd_o        (cmd),
        .cmd_valid_o  (cmd_valid),
        .nak_valid_o  (nak_valid)
    );

    assign tx_start = cmd_valid && (cmd.opcode == OP_UART_SEND);

    // status led follows data bit 0
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            led_o <= 1'b0;
        end else if (cmd_valid && (cmd.opcode == OP_LED)) begin
            led_o <= cmd.data[0];
        end
    end

    // ==================================================
    // command targets
    // ==================================================
    pwm_bank u_pwm (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .cmd_i       (cmd),
        .cmd_valid_i (cmd_valid),
        .pwm_o       (pwm_pins_o)
    );

    uart_port u_uart (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .tx_data_i  (cmd.data),
        .tx_start_i (tx_start),
        .tx_o       (ext_uart_tx_o),
        .rx_i       (ext_uart_rx_i),
        .rx_data_o  (rx_data),
        .rx_valid_o (rx_valid)
    );

    upload_mux u_upload (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .cmd_i       (cmd),
        .cmd_valid_i (cmd_valid),
        .nak_valid_i (nak_valid),
        .rx_data_i   (rx_data),
        .rx_valid_i  (rx_valid),
        .upload_o    (upload)
    );

    // back to the usb core
    assign usb_upload_data_o  = upload.data;
    assign usb_upload_valid_o = upload.valid;

endmodule

//--- tb/cmd_ctrl_checker.sv
`timescale 1ns/1ns

module cmd_ctrl_checker (
    input logic                             clk,
    input logic                             arst_n_i,
    input cmd_pkg::cmd_t                    cmd_i,
    input logic                             cmd_valid_i,
    input logic                             tx_busy_i,
    input logic [7:0]                       usb_upload_data_i,
    input logic                             usb_upload_valid_i,
    input logic [cmd_pkg::PWM_CHANNELS-1:0] pwm_pins_i,
    input logic                             ext_uart_tx_i,
    input logic                             led_i
);
    import cmd_pkg::*;

    // ==================================================
    // reset and line state
    // ==================================================
    reset_values: assert property (@(posedge clk)
        !arst_n_i |-> (pwm_pins_i == '0) && !usb_upload_valid_i && !led_i && ext_uart_tx_i)
        else $error("outputs left their reset values while reset was held");

    upload_known: assert property (@(posedge clk)
        arst_n_i |-> !$isunknown(usb_upload_valid_i))
        else $error("upload valid is unknown");

    tx_idle_high: assert property (@(posedge clk) disable iff (!arst_n_i)
        !tx_busy_i |-> ext_uart_tx_i)
        else $error("uart line low while the transmitter is idle");

    // one cycle after cmd_valid is two after the data byte
    echo_reply: assert property (@(posedge clk) disable iff (!arst_n_i)
        cmd_valid_i && (cmd_i.opcode == OP_ECHO)
        |=> usb_upload_valid_i && (usb_upload_data_i == $past(cmd_i.data)))
        else $error("echo reply missing or wrong two cycles after the data byte");

endmodule

bind cmd_ctrl cmd_ctrl_checker u_checker (
    .clk                (clk),
    .arst_n_i           (arst_n_i),
    .cmd_i              (cmd),
    .cmd_valid_i        (cmd_valid),
    .tx_busy_i          (u_uart.tx_busy),
    .usb_upload_data_i  (usb_upload_data_o),
    .usb_upload_valid_i (usb_upload_valid_o),
    .pwm_pins_i         (pwm_pins_o),
    .ext_uart_tx_i      (ext_uart_tx_o),
    .led_i              (led_o)
);

//--- tb/cmd_ctrl_tb.sv
`timescale 1ns/1ns

module cmd_ctrl_tb;
    import cmd_pkg::*;

    logic                    clk;
    logic                    arst_n_i;
    logic [7:0]              usb_data_i;
    logic                    usb_data_valid_i;
    logic [7:0]              usb_upload_data_o;
    logic                    usb_upload_valid_o;
    logic [PWM_CHANNELS-1:0] pwm_pins_o;
    logic                    ext_uart_tx_o;
    logic                    led_o;

    logic [31:0] rng_q;
    logic [7:0]  up_q [$];
    string       test_name;

    // uart line looped straight back
    cmd_ctrl UUT (
        .clk                (clk),
        .arst_n_i           (arst_n_i),
        .usb_data_i         (usb_data_i),
        .usb_data_valid_i   (usb_data_valid_i),
        .usb_upload_data_o  (usb_upload_data_o),
        .usb_upload_valid_o (usb_upload_valid_o),
        .pwm_pins_o         (pwm_pins_o),
        .ext_uart_rx_i      (ext_uart_tx_o),
        .ext_uart_tx_o      (ext_uart_tx_o),
        .led_o              (led_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // collect every upload byte mid-cycle
    always @(negedge clk) begin
        if (arst_n_i && usb_upload_valid_o) begin
            up_q.push_back(usb_upload_data_o);
        end
    end

    // ==================================================
    // helpers
    // ==================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] next_byte();
        rng_q = xorshift32(rng_q);
        return rng_q[7:0];
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input logic [7:0] exp, input logic [7:0] got);
        assert (got == exp)
            else fail_now($sformatf("ERR %s: expected 0x%02h, actual 0x%02h",
                                    test_name, exp, got));
    endtask

    // sync, opcode, address, data on back to back cycles
    task automatic send_frame(input logic [7:0] op, input logic [7:0] addr,
                              input logic [7:0] data);
        logic [7:0] bytes [4];
        bytes = '{SYNC_BYTE, op, addr, data};
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            usb_data_i       = bytes[i];
            usb_data_valid_i = 1'b1;
        end
        @(posedge clk);
        #1;
        usb_data_valid_i = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        #1;
        usb_data_i       = b;
        usb_data_valid_i = 1'b1;
        @(posedge clk);
        #1;
        usb_data_valid_i = 1'b0;
    endtask

    task automatic expect_upload(input logic [7:0] exp, input int limit);
        int n;
        n = 0;
        while (up_q.size() == 0) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                fail_now($sformatf("%s: no upload byte arrived within %0d cycles",
                                   test_name, limit));
            end
        end
        check_byte(exp, up_q.pop_front());
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) @(negedge clk);
        #1;
        assert (up_q.size() == 0)
            else fail_now($sformatf("%s: unexpected upload byte", test_name));
    endtask

    task automatic wait_led(input logic val, input int limit);
        int n;
        n = 0;
        while (led_o != val) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                fail_now($sformatf("%s: led did not change within %0d cycles",
                                   test_name, limit));
            end
        end
    endtask

    // counts one period from the channel's first rising output
    task automatic check_pwm(input int ch, input logic [7:0] duty);
        int                      n;
        int                      high;
        logic [PWM_CHANNELS-1:0] others;
        n    = 0;
        high = 0;
        while (!pwm_pins_o[ch]) begin
            @(negedge clk);
            n++;
            if (n > 600) begin
                fail_now($sformatf("%s: channel %0d never went high", test_name, ch));
            end
        end
        for (int i = 0; i < 256; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            high   = high + int'(pwm_pins_o[ch]);
            others = pwm_pins_o;
            others[ch] = 1'b0;
            assert (others == '0)
                else fail_now($sformatf("%s: a channel other than %0d went high",
                                        test_name, ch));
        end
        check_byte(duty, 8'(high));
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        logic [7:0] d;
        logic [2:0] ch;
        rng_q            = 32'd41;
        usb_data_i       = '0;
        usb_data_valid_i = 1'b0;
        arst_n_i         = 1'b1;
        #1;
        arst_n_i = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        arst_n_i = 1'b1;

        test_name = "reset";
        @(negedge clk);
        assert (pwm_pins_o == '0 && ext_uart_tx_o && !led_o && !usb_upload_valid_o)
            else fail_now("outputs are not at their reset values after reset");

        // noise ahead of sync must stay silent
        // read as a frame it would be an echo of 0xA7
        test_name = "echo";
        send_byte(8'h00);
        send_byte(8'h04);
        send_byte(8'h13);
        send_byte(8'hA7);
        expect_quiet(20);
        d = next_byte();
        send_frame(OP_ECHO, 8'h00, d);
        expect_upload(d, 20);
        expect_quiet(10);

        test_name = "nak";
        send_frame(8'h7F, next_byte(), next_byte());
        expect_upload(NAK_BYTE, 20);
        expect_quiet(10);

        test_name = "pwm";
        d  = next_byte();
        ch = d[2:0];
        d  = next_byte();
        if (d == 8'd0) begin
            d = 8'd1;
        end
        send_frame(OP_PWM_DUTY, {5'b0, ch}, d);
        check_pwm(int'(ch), d);

        test_name = "uart";
        d = next_byte();
        send_frame(OP_UART_SEND, 8'h00, d);
        expect_upload(d, 300);
        expect_quiet(20);

        test_name = "led";
        send_frame(OP_LED, 8'h00, next_byte() | 8'h01);
        wait_led(1'b1, 10);
        send_frame(OP_LED, 8'h00, next_byte() & 8'hFE);
        wait_led(1'b0, 10);

        $display("Test OK");
        $finish;
    end

endmodule

//--- cmd_ctrl.f
design/cmd_pkg.sv
design/frame_parser.sv
design/pwm_bank.sv
design/uart_port.sv
design/upload_mux.sv
design/cmd_ctrl.sv
tb/cmd_ctrl_checker.sv
tb/cmd_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run, exit status follows the simulation
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module cmd_ctrl_tb -f cmd_ctrl.f -o sim_cmd_ctrl \
    && ./obj_dir/sim_cmd_ctrl \
    || { echo "simulation run failed"; exit 1; }
